// ==== lut_wrapper.f ====
+incdir+rtl
rtl/lut_pkg.sv
rtl/lut_fetch_ctrl.sv
rtl/lut_ram.sv
rtl/lut_exec.sv
rtl/vector_bank.sv
rtl/lut_wrapper.sv
verif/lut_wrapper_tb.sv

// ==== rtl/lut_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lut_params.svh"

module lut_exec (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            i_start,
    input  lut_pkg::vec_t  i_x,
    output logic [7:0]     o_addr,
    input  wire [7:0]      i_q,
    output lut_pkg::vec_t  o_y,
    output logic           o_done
);

    import lut_pkg::*;

    localparam int CNT_W = $clog2(`LUT_N);

    logic busy;
    logic issue_vld;
    logic cap_vld;
    logic last_cap;
    logic [CNT_W-1:0] issue_cnt;
    logic [CNT_W-1:0] cap_cnt;
    vec_t x_q;
    vec_t work;

    // Byte k of the latched vector is the table address
    assign o_addr = x_q[{issue_cnt, 3'd0} +: 8];

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            issue_vld <= 1'b0;
            cap_vld   <= 1'b0;
            last_cap  <= 1'b0;
            issue_cnt <= '0;
            cap_cnt   <= '0;
            o_y       <= '0;
            o_done    <= 1'b0;
        end else begin
            // Capture side trails the issue side by the table read latency
            cap_vld  <= issue_vld;
            cap_cnt  <= issue_cnt;
            last_cap <= cap_vld && (cap_cnt == CNT_W'(`LUT_N - 1));
            o_done   <= last_cap;
            if (!busy && i_start) begin
                busy      <= 1'b1;
                issue_vld <= 1'b1;
                issue_cnt <= '0;
            end else if (issue_vld) begin
                issue_cnt <= issue_cnt + 1'b1;
                if (issue_cnt == CNT_W'(`LUT_N - 1)) begin
                    issue_vld <= 1'b0;
                end
            end
            if (last_cap) begin
                o_y  <= work;
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && i_start) begin
            x_q <= i_x;
        end
        if (cap_vld) begin
            work[{cap_cnt, 3'd0} +: 8] <= i_q;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lut_fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lut_params.svh"

module lut_fetch_ctrl (
    input  wire                 clk,
    input  wire                 rst_n,
    input  lut_pkg::lane_mask_t i_fetch,
    input  wire [31:0]          i_fetch_addr,
    input  wire                 i_sdram_rvalid,
    input  wire [`LUT_SDRAM_W-1:0] i_sdram_rdata,
    output logic                o_sdram_rd,
    output logic [31:0]         o_sdram_addr,
    output lut_pkg::lane_mask_t o_ram_we,
    output logic [7:0]          o_ram_addr,
    output logic [7:0]          o_ram_data,
    output logic                o_fetch_done
);

    import lut_pkg::*;

    localparam int WORD_W = $clog2(`LUT_WORDS);
    localparam int BYTE_W = $clog2(`LUT_SDRAM_W / 8);

    fetch_state_e state;
    lane_mask_t lane_sel;
    lane_mask_t lowest_req;
    logic [31:0] base_addr;
    logic [WORD_W-1:0] word_cnt;
    logic [BYTE_W-1:0] byte_cnt;
    logic [`LUT_SDRAM_W-1:0] word_q;
    logic last_byte;

    // Isolate the lowest set bit of the request mask
    assign lowest_req = i_fetch & (~i_fetch + lane_mask_t'(1));

    assign last_byte = (byte_cnt == BYTE_W'(`LUT_SDRAM_W / 8 - 1));

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            lane_sel     <= '0;
            base_addr    <= '0;
            word_cnt     <= '0;
            byte_cnt     <= '0;
            o_fetch_done <= 1'b0;
        end else begin
            o_fetch_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (|i_fetch) begin
                        lane_sel  <= lowest_req;
                        base_addr <= i_fetch_addr;
                        word_cnt  <= '0;
                        state     <= REQ;
                    end
                end
                REQ: begin
                    state <= WAIT;
                end
                WAIT: begin
                    if (i_sdram_rvalid) begin
                        byte_cnt <= '0;
                        state    <= WRITE;
                    end
                end
                WRITE: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (last_byte) begin
                        if (word_cnt == WORD_W'(`LUT_WORDS - 1)) begin
                            o_fetch_done <= 1'b1;
                            state        <= IDLE;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            state    <= REQ;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Received word, shifted down one byte per write cycle
    always_ff @(posedge clk) begin
        if (state == WAIT && i_sdram_rvalid) begin
            word_q <= i_sdram_rdata;
        end else if (state == WRITE) begin
            word_q <= word_q >> 8;
        end
    end

    assign o_sdram_rd   = (state == REQ);
    assign o_sdram_addr = base_addr + 32'(word_cnt) * (`LUT_SDRAM_W / 8);
    assign o_ram_we     = (state == WRITE) ? lane_sel : '0;
    assign o_ram_addr   = {word_cnt, byte_cnt};
    assign o_ram_data   = word_q[7:0];

endmodule

`default_nettype wire

// ==== rtl/lut_params.svh ====
`ifndef LUT_PARAMS_SVH
`define LUT_PARAMS_SVH

// Lanes, bytes per lane vector and external memory word width
`define LUT_SUB_NUM 4
`define LUT_N       16
`define LUT_SDRAM_W 128

// One table holds an 8-bit entry for every byte value
`define LUT_DEPTH   256
`define LUT_WORDS   ((`LUT_DEPTH * 8) / `LUT_SDRAM_W)

`endif

// ==== rtl/lut_pkg.sv ====
`default_nettype none

`include "lut_params.svh"

package lut_pkg;

    // A whole lane vector, byte 0 in the low bits
    typedef logic [`LUT_N*8-1:0] vec_t;

    // One bit per lane
    typedef logic [`LUT_SUB_NUM-1:0] lane_mask_t;

    // Table load sequencer
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        WRITE
    } fetch_state_e;

endpackage

`default_nettype wire

// ==== rtl/lut_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lut_params.svh"

module lut_ram (
    input  wire       clk,
    input  wire       i_we,
    input  wire [7:0] i_wr_addr,
    input  wire [7:0] i_wr_data,
    input  wire [7:0] i_rd_addr,
    output logic [7:0] o_q
);

    logic [7:0] mem [`LUT_DEPTH];
    logic [7:0] addr;

    // A write takes the single port away from the reader
    assign addr = i_we ? i_wr_addr : i_rd_addr;

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[addr] <= i_wr_data;
        end
        o_q <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== rtl/lut_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lut_params.svh"

module lut_wrapper (
    input  wire                    clk,
    input  wire                    rst_n,
    input  lut_pkg::lane_mask_t    i_fetch,
    input  wire [31:0]             i_fetch_addr,
    input  lut_pkg::lane_mask_t    i_exec,
    input  lut_pkg::lane_mask_t    i_input_we,
    input  lut_pkg::vec_t          i_input_data,
    input  lut_pkg::lane_mask_t    i_output_re,
    output lut_pkg::vec_t          o_output_data,
    output logic                   o_sdram_rd,
    output logic [31:0]            o_sdram_addr,
    input  wire                    i_sdram_rvalid,
    input  wire [`LUT_SDRAM_W-1:0] i_sdram_rdata,
    output logic                   o_fetch_done,
    output lut_pkg::lane_mask_t    o_exec_done
);

    import lut_pkg::*;

    lane_mask_t ram_we;
    logic [7:0] ram_addr;
    logic [7:0] ram_data;
    logic [7:0] rd_addr [`LUT_SUB_NUM];
    logic [7:0] ram_q [`LUT_SUB_NUM];
    vec_t x [`LUT_SUB_NUM];
    vec_t y [`LUT_SUB_NUM];

    lut_fetch_ctrl u_fetch_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_fetch        (i_fetch),
        .i_fetch_addr   (i_fetch_addr),
        .i_sdram_rvalid (i_sdram_rvalid),
        .i_sdram_rdata  (i_sdram_rdata),
        .o_sdram_rd     (o_sdram_rd),
        .o_sdram_addr   (o_sdram_addr),
        .o_ram_we       (ram_we),
        .o_ram_addr     (ram_addr),
        .o_ram_data     (ram_data),
        .o_fetch_done   (o_fetch_done)
    );

    // Each lane pairs its own table with its own executor
    for (genvar g = 0; g < `LUT_SUB_NUM; g++) begin : g_lane
        lut_ram u_ram (
            .clk       (clk),
            .i_we      (ram_we[g]),
            .i_wr_addr (ram_addr),
            .i_wr_data (ram_data),
            .i_rd_addr (rd_addr[g]),
            .o_q       (ram_q[g])
        );

        lut_exec u_exec (
            .clk     (clk),
            .rst_n   (rst_n),
            .i_start (i_exec[g]),
            .i_x     (x[g]),
            .o_addr  (rd_addr[g]),
            .i_q     (ram_q[g]),
            .o_y     (y[g]),
            .o_done  (o_exec_done[g])
        );
    end

    vector_bank u_vector_bank (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_input_we    (i_input_we),
        .i_input_data  (i_input_data),
        .i_output_re   (i_output_re),
        .i_y0          (y[0]),
        .i_y1          (y[1]),
        .i_y2          (y[2]),
        .i_y3          (y[3]),
        .o_x0          (x[0]),
        .o_x1          (x[1]),
        .o_x2          (x[2]),
        .o_x3          (x[3]),
        .o_output_data (o_output_data)
    );

endmodule

`default_nettype wire

// ==== rtl/vector_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lut_params.svh"

module vector_bank (
    input  wire                 clk,
    input  wire                 rst_n,
    input  lut_pkg::lane_mask_t i_input_we,
    input  lut_pkg::vec_t       i_input_data,
    input  lut_pkg::lane_mask_t i_output_re,
    input  lut_pkg::vec_t       i_y0,
    input  lut_pkg::vec_t       i_y1,
    input  lut_pkg::vec_t       i_y2,
    input  lut_pkg::vec_t       i_y3,
    output lut_pkg::vec_t       o_x0,
    output lut_pkg::vec_t       o_x1,
    output lut_pkg::vec_t       o_x2,
    output lut_pkg::vec_t       o_x3,
    output lut_pkg::vec_t       o_output_data
);

    import lut_pkg::*;

    vec_t x_q [`LUT_SUB_NUM];
    vec_t y_in [`LUT_SUB_NUM];

    assign y_in[0] = i_y0;
    assign y_in[1] = i_y1;
    assign y_in[2] = i_y2;
    assign y_in[3] = i_y3;

    assign o_x0 = x_q[0];
    assign o_x1 = x_q[1];
    assign o_x2 = x_q[2];
    assign o_x3 = x_q[3];

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `LUT_SUB_NUM; i++) begin
                x_q[i] <= '0;
            end
            o_output_data <= '0;
        end else begin
            // Ascending scan, so the highest requested lane is written last
            for (int i = 0; i < `LUT_SUB_NUM; i++) begin
                if (i_input_we[i]) begin
                    x_q[i] <= i_input_data;
                end
                if (i_output_re[i]) begin
                    o_output_data <= y_in[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir "$LOG" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module lut_wrapper_tb -f lut_wrapper.f -o lut_sim &&
./obj_dir/lut_sim > "$LOG" 2>&1 ||
echo "build or simulation did not complete"

cat "$LOG" 2>/dev/null
grep -qx "=== PASS ===" "$LOG" && echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }

// ==== verif/lut_wrapper_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lut_params.svh"

module lut_wrapper_tb;

    import lut_pkg::*;

    localparam int EXEC_LAT    = `LUT_N + 2;
    localparam int EXEC_LIMIT  = 64;
    localparam int FETCH_LIMIT = 2000;

    logic                    clk;
    logic                    rst_n;
    lane_mask_t              i_fetch;
    logic [31:0]             i_fetch_addr;
    lane_mask_t              i_exec;
    lane_mask_t              i_input_we;
    vec_t                    i_input_data;
    lane_mask_t              i_output_re;
    vec_t                    o_output_data;
    logic                    o_sdram_rd;
    logic [31:0]             o_sdram_addr;
    logic                    i_sdram_rvalid;
    logic [`LUT_SDRAM_W-1:0] i_sdram_rdata;
    logic                    o_fetch_done;
    lane_mask_t              o_exec_done;

    // External memory contents and the addresses requested from it
    logic [`LUT_SDRAM_W-1:0] mem_words [logic [31:0]];
    logic [31:0]             rd_log [$];
    int unsigned             resp_delay [256];

    // Reference model of the lanes
    logic [7:0] ref_tab [`LUT_SUB_NUM][`LUT_DEPTH];
    vec_t       ref_x [`LUT_SUB_NUM];
    vec_t       ref_y [`LUT_SUB_NUM];
    vec_t       ref_out;

    string cur_test;
    int    test_errs;
    int    total_errs;
    int    checks;
    int    tests_run;
    int    tests_failed;
    bit    hard_fail;

    lut_wrapper uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_fetch        (i_fetch),
        .i_fetch_addr   (i_fetch_addr),
        .i_exec         (i_exec),
        .i_input_we     (i_input_we),
        .i_input_data   (i_input_data),
        .i_output_re    (i_output_re),
        .o_output_data  (o_output_data),
        .o_sdram_rd     (o_sdram_rd),
        .o_sdram_addr   (o_sdram_addr),
        .i_sdram_rvalid (i_sdram_rvalid),
        .i_sdram_rdata  (i_sdram_rdata),
        .o_fetch_done   (o_fetch_done),
        .o_exec_done    (o_exec_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Unwritten memory returns a pattern built from the whole address
    function automatic logic [`LUT_SDRAM_W-1:0] word_at(input logic [31:0] a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return {a, ~a, a ^ 32'h5a5a_c3c3, a + 32'h0137_9bdf};
    endfunction

    function automatic vec_t rand_vec();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic vec_t model_lookup(input int lane);
        vec_t r;
        for (int b = 0; b < `LUT_N; b++) begin
            r[8*b +: 8] = ref_tab[lane][ref_x[lane][8*b +: 8]];
        end
        return r;
    endfunction

    // Memory answers each read strobe after a delay taken from the table
    initial begin : sdram_model
        logic [7:0]  rd_idx;
        logic [31:0] a;
        rd_idx = '0;
        i_sdram_rvalid = 1'b0;
        i_sdram_rdata = '0;
        forever begin
            @(negedge clk);
            if (rst_n && o_sdram_rd) begin
                a = o_sdram_addr;
                rd_log.push_back(a);
                repeat (resp_delay[rd_idx]) @(negedge clk);
                rd_idx++;
                i_sdram_rvalid = 1'b1;
                i_sdram_rdata = word_at(a);
                @(negedge clk);
                i_sdram_rvalid = 1'b0;
            end
        end
    end

    task automatic end_run();
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, total_errs);
        if (tests_failed == 0 && total_errs == 0 && !hard_fail) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        fetch_state_e st;
        st = uut.u_fetch_ctrl.state;
        $display("test %s stopped, no %s within the time limit, fetch controller in %s",
                 cur_test, what, st.name());
        test_errs++;
        hard_fail = 1'b1;
    endtask

    task automatic check_val(input string what, input logic [127:0] exp,
                             input logic [127:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, test_errs);
        end
    endtask

    task automatic fill_mem(input logic [31:0] base);
        for (int w = 0; w < `LUT_WORDS; w++) begin
            mem_words[base + 32'(16 * w)] = rand_vec();
        end
    endtask

    task automatic fetch_table(input lane_mask_t mask, input logic [31:0] base);
        int cnt;
        int lane;
        logic [`LUT_SDRAM_W-1:0] wv;
        @(negedge clk);
        i_fetch = mask;
        i_fetch_addr = base;
        @(negedge clk);
        i_fetch = '0;
        cnt = 0;
        while (!o_fetch_done && !hard_fail) begin
            @(negedge clk);
            cnt++;
            if (cnt > FETCH_LIMIT) begin
                report_timeout("fetch done pulse");
            end
        end
        // Lowest requested lane receives the table
        lane = 0;
        for (int k = `LUT_SUB_NUM - 1; k >= 0; k--) begin
            if (mask[k]) begin
                lane = k;
            end
        end
        for (int w = 0; w < `LUT_WORDS; w++) begin
            wv = word_at(base + 32'(16 * w));
            for (int j = 0; j < 16; j++) begin
                ref_tab[lane][16 * w + j] = wv[8*j +: 8];
            end
        end
    endtask

    task automatic write_vec(input lane_mask_t mask, input vec_t v);
        @(negedge clk);
        i_input_we = mask;
        i_input_data = v;
        @(negedge clk);
        i_input_we = '0;
        for (int k = 0; k < `LUT_SUB_NUM; k++) begin
            if (mask[k]) begin
                ref_x[k] = v;
            end
        end
    endtask

    task automatic run_lanes(input lane_mask_t mask);
        int cnt;
        lane_mask_t seen;
        lane_mask_t done_now;
        @(negedge clk);
        i_exec = mask;
        cnt = 0;
        seen = '0;
        while (seen != mask && !hard_fail) begin
            @(negedge clk);
            i_exec = '0;
            cnt++;
            if (cnt > EXEC_LIMIT) begin
                report_timeout("execution done pulse");
            end
            done_now = o_exec_done & mask;
            for (int k = 0; k < `LUT_SUB_NUM; k++) begin
                if (done_now[k]) begin
                    // The start was sampled one edge before the first count
                    check_val($sformatf("exec latency lane %0d", k),
                              128'(EXEC_LAT), 128'(cnt - 1));
                    ref_y[k] = model_lookup(k);
                end
            end
            seen = seen | done_now;
        end
    endtask

    task automatic read_out(input lane_mask_t mask, input string what);
        int hi;
        hi = -1;
        @(negedge clk);
        i_output_re = mask;
        @(negedge clk);
        i_output_re = '0;
        for (int k = 0; k < `LUT_SUB_NUM; k++) begin
            if (mask[k]) begin
                hi = k;
            end
        end
        if (hi >= 0) begin
            ref_out = ref_y[hi];
        end
        check_val($sformatf("%s mask %b", what, mask), ref_out, o_output_data);
    endtask

    task automatic read_all(input string what);
        for (int k = 0; k < `LUT_SUB_NUM; k++) begin
            read_out(lane_mask_t'(1 << k), what);
        end
    endtask

    task automatic load_and_lookup();
        logic [31:0] base;
        start_test("load_lookup");
        base = $urandom;
        fill_mem(base);
        rd_log.delete();
        fetch_table(4'b0001, base);
        check_val("read count", 128'(`LUT_WORDS), 128'(rd_log.size()));
        for (int w = 0; w < rd_log.size() && w < `LUT_WORDS; w++) begin
            check_val($sformatf("read addr %0d", w), 128'(base + 32'(16 * w)),
                      128'(rd_log[w]));
        end
        write_vec(4'b0001, rand_vec());
        run_lanes(4'b0001);
        read_out(4'b0001, "lookup");
        finish_test();
    endtask

    task automatic lowest_lane_select();
        logic [31:0] base;
        start_test("lane_select");
        for (int k = 1; k < `LUT_SUB_NUM; k++) begin
            base = $urandom;
            fill_mem(base);
            fetch_table(lane_mask_t'(1 << k), base);
        end
        for (int k = 0; k < `LUT_SUB_NUM; k++) begin
            write_vec(lane_mask_t'(1 << k), rand_vec());
        end
        run_lanes(4'b1111);
        read_all("before");
        base = $urandom;
        fill_mem(base);
        fetch_table(4'b1110, base);
        run_lanes(4'b1111);
        read_all("after 1110");
        base = $urandom;
        fill_mem(base);
        fetch_table(4'b1100, base);
        run_lanes(4'b1111);
        read_all("after 1100");
        finish_test();
    endtask

    task automatic measure_exec_latency();
        start_test("exec_latency");
        for (int k = 0; k < `LUT_SUB_NUM; k++) begin
            write_vec(lane_mask_t'(1 << k), rand_vec());
        end
        run_lanes(4'b1111);
        read_all("all lanes");
        write_vec(4'b0101, rand_vec());
        run_lanes(4'b0101);
        run_lanes(4'b1000);
        read_all("pairs");
        finish_test();
    endtask

    task automatic output_mux_reads();
        start_test("output_mux");
        read_out(4'b0001, "single");
        read_out(4'b0110, "multi");
        read_out(4'b0000, "hold");
        read_out(4'b1001, "multi");
        read_out(4'b1111, "all");
        read_out(4'b0000, "hold");
        read_out(4'b0100, "single");
        finish_test();
    endtask

    task automatic random_soak();
        int unsigned op;
        lane_mask_t mask;
        logic [31:0] base;
        start_test("soak");
        for (int it = 0; it < 80; it++) begin
            op = $urandom_range(0, 3);
            mask = 4'($urandom_range(0, 15));
            case (op)
                0: begin
                    if (mask != 0) begin
                        base = $urandom;
                        fill_mem(base);
                        fetch_table(mask, base);
                    end
                end
                1: write_vec(mask, rand_vec());
                2: begin
                    if (mask != 0) begin
                        run_lanes(mask);
                    end
                end
                default: read_out(mask, "soak read");
            endcase
        end
        read_all("soak final");
        finish_test();
    endtask

    initial begin
        void'($urandom(86));
        rst_n = 1'b0;
        i_fetch = '0;
        i_fetch_addr = '0;
        i_exec = '0;
        i_input_we = '0;
        i_input_data = '0;
        i_output_re = '0;
        for (int k = 0; k < `LUT_SUB_NUM; k++) begin
            ref_x[k] = '0;
            ref_y[k] = '0;
        end
        ref_out = '0;
        for (int i = 0; i < 256; i++) begin
            resp_delay[i] = $urandom_range(1, 6);
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test("reset");
        check_val("sdram rd", 128'(0), 128'(o_sdram_rd));
        check_val("fetch done", 128'(0), 128'(o_fetch_done));
        check_val("exec done", 128'(0), 128'(o_exec_done));
        check_val("output data", 128'(0), o_output_data);
        finish_test();

        load_and_lookup();
        lowest_lane_select();
        measure_exec_latency();
        output_mux_reads();
        random_soak();
        end_run();
    end

endmodule

`default_nettype wire
